// File: source/ex_config.svh
// widths for an rv64 core; the ALU and register file assume XLEN is 64 and 32 registers
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// data and address width
`define XLEN 64

// register index width
`define REG_ADDR_W 5

// number of general registers, x0 included
`define REG_NUM (1 << `REG_ADDR_W)

`endif

// File: source/ex_pkg.sv
// operation codes shared by decode and execute; the branch kind needs 4 bits for its 9 values
package ex_pkg;

  // ALU operation
  // pass_op2 carries the lui immediate or the jal link address chosen by decode
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_op2
  } alu_op_e;

  // branch and jump kind
  typedef enum logic [3:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jal,
    br_jalr
  } branch_op_e;

endpackage

// File: source/gpr_file.sv
// reads are combinational with no write bypass; a same-cycle writeback is covered by forwarding
`timescale 1ns/10ps
`include "ex_config.svh"

module gpr_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  logic                   wb_wr,
  input  logic [`REG_ADDR_W-1:0] wb_addr,
  input  logic [`XLEN-1:0]       wb_data
);

  logic [`XLEN-1:0] regs [`REG_NUM];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_wr && (wb_addr != '0)) begin
      // x0 never takes a write
      regs[wb_addr] <= wb_data;
    end
  end

  // x0 reads zero even before the first reset
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: source/ex_forward.sv
// memory beats writeback beats the register file; a pending load only raises hazard
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_forward (
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic                   use_rs1,
  input  logic                   use_rs2,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  input  logic                   mem_fwd_wr,
  input  logic                   mem_fwd_load,
  input  logic [`REG_ADDR_W-1:0] mem_fwd_addr,
  input  logic [`XLEN-1:0]       mem_fwd_data,
  input  logic                   wb_wr,
  input  logic [`REG_ADDR_W-1:0] wb_addr,
  input  logic [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]       rs1_value,
  output logic [`XLEN-1:0]       rs2_value,
  output logic                   hazard
);

  logic rs1_load_hit;
  logic rs2_load_hit;

  // youngest producer wins
  function automatic logic [`XLEN-1:0] pick(input logic [`REG_ADDR_W-1:0] addr,
                                            input logic [`XLEN-1:0]       rf_data);
    if (addr == '0) begin
      return '0;
    end
    if (mem_fwd_wr && (mem_fwd_addr == addr)) begin
      return mem_fwd_data;
    end
    if (wb_wr && (wb_addr == addr)) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  always_comb begin
    rs1_value = pick(rs1_addr, rs1_data);
    rs2_value = pick(rs2_addr, rs2_data);
  end

  // load data shows up only after the memory stage
  assign rs1_load_hit = use_rs1 && (rs1_addr != '0) && (rs1_addr == mem_fwd_addr);
  assign rs2_load_hit = use_rs2 && (rs2_addr != '0) && (rs2_addr == mem_fwd_addr);
  assign hazard = mem_fwd_wr && mem_fwd_load && (rs1_load_hit || rs2_load_hit);

endmodule

// File: source/ex_alu.sv
// word mode truncates to 32 bits and sign-extends the result; XLEN must be 64
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_alu (
  input  logic [`XLEN-1:0] op1,
  input  logic [`XLEN-1:0] op2,
  input  ex_pkg::alu_op_e  alu_op,
  input  logic             word,
  output logic [`XLEN-1:0] result
);

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic [`XLEN-1:0] raw;
  logic [5:0]       shamt;
  logic [31:0]      sra_word;
  logic [`XLEN-1:0] sra_full;

  // upper halves cleared for the *w forms
  assign a = word ? {32'b0, op1[31:0]} : op1;
  assign b = word ? {32'b0, op2[31:0]} : op2;
  assign shamt = word ? {1'b0, op2[4:0]} : op2[5:0];

  // sraw shifts in bit 31, not the cleared bit 63
  assign sra_word = $signed(a[31:0]) >>> shamt[4:0];
  assign sra_full = $signed(a) >>> shamt;

  always_comb begin
    case (alu_op)
      ex_pkg::alu_add:      raw = a + b;
      ex_pkg::alu_sub:      raw = a - b;
      ex_pkg::alu_sll:      raw = a << shamt;
      ex_pkg::alu_slt:      raw = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ex_pkg::alu_sltu:     raw = {{(`XLEN-1){1'b0}}, a < b};
      ex_pkg::alu_xor:      raw = a ^ b;
      ex_pkg::alu_srl:      raw = a >> shamt;
      ex_pkg::alu_sra:      raw = word ? {32'b0, sra_word} : sra_full;
      ex_pkg::alu_or:       raw = a | b;
      ex_pkg::alu_and:      raw = a & b;
      ex_pkg::alu_pass_op2: raw = b;
      default:              raw = '0;
    endcase
  end

  assign result = word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// File: source/ex_branch.sv
// condition and target only; operands must already be forwarded and hazard free
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_branch (
  input  ex_pkg::branch_op_e branch_op,
  input  logic [`XLEN-1:0]   rs1_value,
  input  logic [`XLEN-1:0]   rs2_value,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   imm,
  output logic               taken,
  output logic [`XLEN-1:0]   target
);

  logic [`XLEN-1:0] jalr_sum;

  always_comb begin
    case (branch_op)
      ex_pkg::br_beq:  taken = rs1_value == rs2_value;
      ex_pkg::br_bne:  taken = rs1_value != rs2_value;
      ex_pkg::br_blt:  taken = $signed(rs1_value) < $signed(rs2_value);
      ex_pkg::br_bge:  taken = $signed(rs1_value) >= $signed(rs2_value);
      ex_pkg::br_bltu: taken = rs1_value < rs2_value;
      ex_pkg::br_bgeu: taken = rs1_value >= rs2_value;
      ex_pkg::br_jal:  taken = 1'b1;
      ex_pkg::br_jalr: taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  // jalr drops bit 0 of the sum
  assign jalr_sum = rs1_value + imm;
  assign target = (branch_op == ex_pkg::br_jalr) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + imm;

endmodule

// File: source/ex_stage.sv
// single-entry stage; a branch leaves only in a cycle where fetch also takes its redirect
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   id_valid,
  output logic                   ex_allowin,
  input  logic [`XLEN-1:0]       id_pc,
  input  ex_pkg::alu_op_e        id_alu_op,
  input  ex_pkg::branch_op_e     id_branch_op,
  input  logic                   id_word,
  input  logic                   id_use_rs1,
  input  logic                   id_use_rs2,
  input  logic [`REG_ADDR_W-1:0] id_rs1_addr,
  input  logic [`REG_ADDR_W-1:0] id_rs2_addr,
  input  logic [`XLEN-1:0]       id_op1,
  input  logic [`XLEN-1:0]       id_op2,
  input  logic [`XLEN-1:0]       id_imm,
  input  logic                   id_rd_wr,
  input  logic [`REG_ADDR_W-1:0] id_rd_addr,
  output logic                   mem_valid,
  input  logic                   mem_allowin,
  output logic [`XLEN-1:0]       mem_pc,
  output logic [`XLEN-1:0]       mem_result,
  output logic [`XLEN-1:0]       mem_store_data,
  output logic                   mem_rd_wr,
  output logic [`REG_ADDR_W-1:0] mem_rd_addr,
  input  logic                   mem_fwd_wr,
  input  logic                   mem_fwd_load,
  input  logic [`REG_ADDR_W-1:0] mem_fwd_addr,
  input  logic [`XLEN-1:0]       mem_fwd_data,
  input  logic                   wb_wr,
  input  logic [`REG_ADDR_W-1:0] wb_addr,
  input  logic [`XLEN-1:0]       wb_data,
  output logic                   bj_valid,
  input  logic                   bj_ready,
  output logic                   bj_taken,
  output logic [`XLEN-1:0]       bj_target,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data
);

  logic                   ex_valid;
  logic [`XLEN-1:0]       ex_pc;
  ex_pkg::alu_op_e        ex_alu_op;
  ex_pkg::branch_op_e     ex_branch_op;
  logic                   ex_word;
  logic                   ex_use_rs1;
  logic                   ex_use_rs2;
  logic [`REG_ADDR_W-1:0] ex_rs1_addr;
  logic [`REG_ADDR_W-1:0] ex_rs2_addr;
  logic [`XLEN-1:0]       ex_op1;
  logic [`XLEN-1:0]       ex_op2;
  logic [`XLEN-1:0]       ex_imm;
  logic                   ex_rd_wr;
  logic [`REG_ADDR_W-1:0] ex_rd_addr;
  logic [`XLEN-1:0]       rs1_value;
  logic [`XLEN-1:0]       rs2_value;
  logic [`XLEN-1:0]       alu_op1;
  logic [`XLEN-1:0]       alu_op2;
  logic                   hazard;
  logic                   is_branch;
  logic                   ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid && ex_allowin) begin
      ex_pc        <= id_pc;
      ex_alu_op    <= id_alu_op;
      ex_branch_op <= id_branch_op;
      ex_word      <= id_word;
      ex_use_rs1   <= id_use_rs1;
      ex_use_rs2   <= id_use_rs2;
      ex_rs1_addr  <= id_rs1_addr;
      ex_rs2_addr  <= id_rs2_addr;
      ex_op1       <= id_op1;
      ex_op2       <= id_op2;
      ex_imm       <= id_imm;
      ex_rd_wr     <= id_rd_wr;
      ex_rd_addr   <= id_rd_addr;
    end
  end

  // handshake control
  assign is_branch  = ex_branch_op != ex_pkg::br_none;
  assign bj_valid   = ex_valid && is_branch && !hazard;
  assign ready_go   = !hazard && (!is_branch || (bj_valid && bj_ready));
  assign mem_valid  = ex_valid && ready_go;
  assign ex_allowin = !ex_valid || (ready_go && mem_allowin);

  assign rs1_addr = ex_rs1_addr;
  assign rs2_addr = ex_rs2_addr;

  ex_forward i_ex_forward (
    .rs1_addr     (ex_rs1_addr),
    .rs2_addr     (ex_rs2_addr),
    .use_rs1      (ex_use_rs1),
    .use_rs2      (ex_use_rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .mem_fwd_wr   (mem_fwd_wr),
    .mem_fwd_load (mem_fwd_load),
    .mem_fwd_addr (mem_fwd_addr),
    .mem_fwd_data (mem_fwd_data),
    .wb_wr        (wb_wr),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .hazard       (hazard)
  );

  // register values replace decode operands only where used
  assign alu_op1 = ex_use_rs1 ? rs1_value : ex_op1;
  assign alu_op2 = ex_use_rs2 ? rs2_value : ex_op2;

  ex_alu i_ex_alu (
    .op1    (alu_op1),
    .op2    (alu_op2),
    .alu_op (ex_alu_op),
    .word   (ex_word),
    .result (mem_result)
  );

  ex_branch i_ex_branch (
    .branch_op (ex_branch_op),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .pc        (ex_pc),
    .imm       (ex_imm),
    .taken     (bj_taken),
    .target    (bj_target)
  );

  assign mem_pc         = ex_pc;
  assign mem_store_data = rs2_value;
  assign mem_rd_wr      = ex_rd_wr;
  assign mem_rd_addr    = ex_rd_addr;

  // a load still in the memory stage keeps the instruction in place
  a_hazard_holds: assert property (@(posedge clk) disable iff (rst)
    ex_valid && hazard |=> ex_valid && $stable(mem_pc) && $stable(mem_rd_addr));

  // memory back-pressure holds the instruction in place
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    mem_valid && !mem_allowin |=> ex_valid && $stable(mem_pc) && $stable(mem_rd_wr)
      && $stable(mem_rd_addr));

endmodule

// File: source/ex_top.sv
// execute stage plus register file; fetch, decode, memory and writeback live outside
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   id_valid,
  output logic                   ex_allowin,
  input  logic [`XLEN-1:0]       id_pc,
  input  ex_pkg::alu_op_e        id_alu_op,
  input  ex_pkg::branch_op_e     id_branch_op,
  input  logic                   id_word,
  input  logic                   id_use_rs1,
  input  logic                   id_use_rs2,
  input  logic [`REG_ADDR_W-1:0] id_rs1_addr,
  input  logic [`REG_ADDR_W-1:0] id_rs2_addr,
  input  logic [`XLEN-1:0]       id_op1,
  input  logic [`XLEN-1:0]       id_op2,
  input  logic [`XLEN-1:0]       id_imm,
  input  logic                   id_rd_wr,
  input  logic [`REG_ADDR_W-1:0] id_rd_addr,
  output logic                   mem_valid,
  input  logic                   mem_allowin,
  output logic [`XLEN-1:0]       mem_pc,
  output logic [`XLEN-1:0]       mem_result,
  output logic [`XLEN-1:0]       mem_store_data,
  output logic                   mem_rd_wr,
  output logic [`REG_ADDR_W-1:0] mem_rd_addr,
  input  logic                   mem_fwd_wr,
  input  logic                   mem_fwd_load,
  input  logic [`REG_ADDR_W-1:0] mem_fwd_addr,
  input  logic [`XLEN-1:0]       mem_fwd_data,
  input  logic                   wb_wr,
  input  logic [`REG_ADDR_W-1:0] wb_addr,
  input  logic [`XLEN-1:0]       wb_data,
  output logic                   bj_valid,
  input  logic                   bj_ready,
  output logic                   bj_taken,
  output logic [`XLEN-1:0]       bj_target
);

  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  ex_stage i_ex_stage (
    .clk            (clk),
    .rst            (rst),
    .id_valid       (id_valid),
    .ex_allowin     (ex_allowin),
    .id_pc          (id_pc),
    .id_alu_op      (id_alu_op),
    .id_branch_op   (id_branch_op),
    .id_word        (id_word),
    .id_use_rs1     (id_use_rs1),
    .id_use_rs2     (id_use_rs2),
    .id_rs1_addr    (id_rs1_addr),
    .id_rs2_addr    (id_rs2_addr),
    .id_op1         (id_op1),
    .id_op2         (id_op2),
    .id_imm         (id_imm),
    .id_rd_wr       (id_rd_wr),
    .id_rd_addr     (id_rd_addr),
    .mem_valid      (mem_valid),
    .mem_allowin    (mem_allowin),
    .mem_pc         (mem_pc),
    .mem_result     (mem_result),
    .mem_store_data (mem_store_data),
    .mem_rd_wr      (mem_rd_wr),
    .mem_rd_addr    (mem_rd_addr),
    .mem_fwd_wr     (mem_fwd_wr),
    .mem_fwd_load   (mem_fwd_load),
    .mem_fwd_addr   (mem_fwd_addr),
    .mem_fwd_data   (mem_fwd_data),
    .wb_wr          (wb_wr),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data),
    .bj_valid       (bj_valid),
    .bj_ready       (bj_ready),
    .bj_taken       (bj_taken),
    .bj_target      (bj_target),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data)
  );

  // writeback also feeds the forwarding path above
  gpr_file i_gpr_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_wr    (wb_wr),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

endmodule

// File: tests/ex_model.svh
// execute stage reference model; included inside the testbench module, reads its forwarding signals
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// register contents as left by the writeback port
logic [`XLEN-1:0] reg_mirror [`REG_NUM];

// memory stage first, then writeback, then the mirror
function automatic logic [`XLEN-1:0] fwd_value(input logic [`REG_ADDR_W-1:0] addr);
  if (addr == '0) begin
    return '0;
  end
  if (mem_fwd_wr && (mem_fwd_addr == addr)) begin
    return mem_fwd_data;
  end
  if (wb_wr && (wb_addr == addr)) begin
    return wb_data;
  end
  return reg_mirror[addr];
endfunction

function automatic logic load_hazard(input logic use1, input logic use2,
                                     input logic [`REG_ADDR_W-1:0] rs1,
                                     input logic [`REG_ADDR_W-1:0] rs2);
  logic hit1;
  logic hit2;
  hit1 = use1 && (rs1 != '0) && (rs1 == mem_fwd_addr);
  hit2 = use2 && (rs2 != '0) && (rs2 == mem_fwd_addr);
  return mem_fwd_wr && mem_fwd_load && (hit1 || hit2);
endfunction

function automatic logic [`XLEN-1:0] calc_alu(input logic [`XLEN-1:0] op1,
                                              input logic [`XLEN-1:0] op2,
                                              input ex_pkg::alu_op_e alu_op,
                                              input logic word);
  logic [31:0]      lo;
  logic [`XLEN-1:0] full;
  if (word) begin
    // addw, subw, sllw, srlw, sraw on the low halves
    case (alu_op)
      ex_pkg::alu_add: lo = op1[31:0] + op2[31:0];
      ex_pkg::alu_sub: lo = op1[31:0] - op2[31:0];
      ex_pkg::alu_sll: lo = op1[31:0] << op2[4:0];
      ex_pkg::alu_srl: lo = op1[31:0] >> op2[4:0];
      ex_pkg::alu_sra: lo = $signed(op1[31:0]) >>> op2[4:0];
      default:         lo = 32'h0;
    endcase
    return {{32{lo[31]}}, lo};
  end
  full = '0;
  case (alu_op)
    ex_pkg::alu_add:      full = op1 + op2;
    ex_pkg::alu_sub:      full = op1 - op2;
    ex_pkg::alu_sll:      full = op1 << op2[5:0];
    ex_pkg::alu_slt:      full[0] = $signed(op1) < $signed(op2);
    ex_pkg::alu_sltu:     full[0] = op1 < op2;
    ex_pkg::alu_xor:      full = op1 ^ op2;
    ex_pkg::alu_srl:      full = op1 >> op2[5:0];
    ex_pkg::alu_sra:      full = $signed(op1) >>> op2[5:0];
    ex_pkg::alu_or:       full = op1 | op2;
    ex_pkg::alu_and:      full = op1 & op2;
    ex_pkg::alu_pass_op2: full = op2;
    default:              full = '0;
  endcase
  return full;
endfunction

function automatic logic calc_taken(input ex_pkg::branch_op_e op,
                                    input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
  case (op)
    ex_pkg::br_beq:  return a == b;
    ex_pkg::br_bne:  return a != b;
    ex_pkg::br_blt:  return $signed(a) < $signed(b);
    ex_pkg::br_bge:  return $signed(a) >= $signed(b);
    ex_pkg::br_bltu: return a < b;
    ex_pkg::br_bgeu: return a >= b;
    ex_pkg::br_jal:  return 1'b1;
    ex_pkg::br_jalr: return 1'b1;
    default:         return 1'b0;
  endcase
endfunction

function automatic logic [`XLEN-1:0] calc_target(input ex_pkg::branch_op_e op,
                                                 input logic [`XLEN-1:0] pc,
                                                 input logic [`XLEN-1:0] imm,
                                                 input logic [`XLEN-1:0] a);
  logic [`XLEN-1:0] sum;
  if (op == ex_pkg::br_jalr) begin
    sum = a + imm;
    sum[0] = 1'b0;
    return sum;
  end
  return pc + imm;
endfunction

// follows the write that lands at the next rising edge
task automatic mirror_update(input logic clear);
  if (clear) begin
    for (int i = 0; i < `REG_NUM; i++) begin
      reg_mirror[i] = '0;
    end
  end else if (wb_wr && (wb_addr != '0)) begin
    reg_mirror[wb_addr] = wb_data;
  end
endtask

`endif

// File: tests/tb_ex_top.sv
// random traffic against a model with one fixed seed; assumes XLEN 64 and one instruction in flight
`timescale 1ns/10ps
`include "ex_config.svh"

module tb_ex_top;

  localparam int NUM_INSTR      = 2000;
  localparam int CLK_PERIOD     = 4;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    ex_pkg::alu_op_e        alu_op;
    ex_pkg::branch_op_e     branch_op;
    logic                   word;
    logic                   use_rs1;
    logic                   use_rs2;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [`XLEN-1:0]       imm;
    logic                   rd_wr;
    logic [`REG_ADDR_W-1:0] rd_addr;
  } instr_rec_t;

  logic                   clk;
  logic                   rst;
  logic                   id_valid;
  logic                   ex_allowin;
  logic [`XLEN-1:0]       id_pc;
  ex_pkg::alu_op_e        id_alu_op;
  ex_pkg::branch_op_e     id_branch_op;
  logic                   id_word;
  logic                   id_use_rs1;
  logic                   id_use_rs2;
  logic [`REG_ADDR_W-1:0] id_rs1_addr;
  logic [`REG_ADDR_W-1:0] id_rs2_addr;
  logic [`XLEN-1:0]       id_op1;
  logic [`XLEN-1:0]       id_op2;
  logic [`XLEN-1:0]       id_imm;
  logic                   id_rd_wr;
  logic [`REG_ADDR_W-1:0] id_rd_addr;
  logic                   mem_valid;
  logic                   mem_allowin;
  logic [`XLEN-1:0]       mem_pc;
  logic [`XLEN-1:0]       mem_result;
  logic [`XLEN-1:0]       mem_store_data;
  logic                   mem_rd_wr;
  logic [`REG_ADDR_W-1:0] mem_rd_addr;
  logic                   mem_fwd_wr;
  logic                   mem_fwd_load;
  logic [`REG_ADDR_W-1:0] mem_fwd_addr;
  logic [`XLEN-1:0]       mem_fwd_data;
  logic                   wb_wr;
  logic [`REG_ADDR_W-1:0] wb_addr;
  logic [`XLEN-1:0]       wb_data;
  logic                   bj_valid;
  logic                   bj_ready;
  logic                   bj_taken;
  logic [`XLEN-1:0]       bj_target;

  `include "ex_model.svh"

  // instructions accepted and not yet retired, oldest first
  instr_rec_t pending [$];
  int error_count;
  int accepted_count;
  int retired_count;
  // ex_allowin as seen at the last falling edge
  logic allowin_seen;

  ex_top i_ex_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] expected,
                         input string what);
    if (got !== expected) begin
      error_count++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // true once in n calls on average
  function automatic logic chance(input int unsigned n);
    return $urandom_range(0, n - 1) == 0;
  endfunction

  function automatic logic [`XLEN-1:0] rand_dword();
    return {$urandom, $urandom};
  endfunction

  // few registers so that forwarding and hazards hit often
  function automatic logic [`REG_ADDR_W-1:0] rand_reg();
    logic [31:0] r;
    r = $urandom_range(0, 7);
    return r[`REG_ADDR_W-1:0];
  endfunction

  task automatic new_instr();
    logic [31:0]      pick;
    logic [`XLEN-1:0] pc_val;
    ex_pkg::alu_op_e  op;
    pick = $urandom_range(0, 10);
    op = ex_pkg::alu_op_e'(pick[3:0]);
    pc_val = rand_dword();
    id_valid <= !chance(4);
    id_pc <= {pc_val[`XLEN-1:2], 2'b00};
    id_alu_op <= op;
    // word flag only on ops that have an rv64 word form
    id_word <= (op inside {ex_pkg::alu_add, ex_pkg::alu_sub, ex_pkg::alu_sll,
                           ex_pkg::alu_srl, ex_pkg::alu_sra}) && chance(2);
    pick = $urandom_range(1, 8);
    if (chance(4)) begin
      id_branch_op <= ex_pkg::branch_op_e'(pick[3:0]);
    end else begin
      id_branch_op <= ex_pkg::br_none;
    end
    id_use_rs1 <= !chance(4);
    id_use_rs2 <= chance(2);
    id_rs1_addr <= rand_reg();
    id_rs2_addr <= rand_reg();
    id_op1 <= rand_dword();
    id_op2 <= rand_dword();
    id_imm <= rand_dword();
    id_rd_wr <= chance(2);
    id_rd_addr <= rand_reg();
  endtask

  // decode holds an offered instruction until the stage takes it
  task automatic drive_cycle();
    if (!id_valid || allowin_seen) begin
      new_instr();
    end
    mem_allowin <= !chance(4);
    bj_ready <= !chance(3);
    mem_fwd_wr <= chance(2);
    mem_fwd_load <= chance(4);
    mem_fwd_addr <= rand_reg();
    mem_fwd_data <= rand_dword();
    wb_wr <= chance(2);
    wb_addr <= rand_reg();
    wb_data <= rand_dword();
  endtask

  task automatic check_cycle();
    instr_rec_t       rec;
    instr_rec_t       incoming;
    logic [`XLEN-1:0] v1;
    logic [`XLEN-1:0] v2;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic             haz;
    logic             is_br;
    logic             exp_mem_valid;
    logic             exp_allowin;
    if (pending.size() == 0) begin
      compare(mem_valid, 1'b0, "mem_valid with stage empty");
      compare(bj_valid, 1'b0, "bj_valid with stage empty");
      compare(ex_allowin, 1'b1, "ex_allowin with stage empty");
      exp_allowin = 1'b1;
    end else begin
      rec = pending[0];
      v1 = fwd_value(rec.rs1_addr);
      v2 = fwd_value(rec.rs2_addr);
      haz = load_hazard(rec.use_rs1, rec.use_rs2, rec.rs1_addr, rec.rs2_addr);
      is_br = rec.branch_op != ex_pkg::br_none;
      exp_mem_valid = !haz && (!is_br || bj_ready);
      exp_allowin = exp_mem_valid && mem_allowin;
      compare(mem_valid, exp_mem_valid, "mem_valid");
      compare(bj_valid, !haz && is_br, "bj_valid");
      compare(ex_allowin, exp_allowin, "ex_allowin");
      // held fields stay put under back-pressure
      compare(mem_pc, rec.pc, "mem_pc");
      compare(mem_rd_wr, rec.rd_wr, "mem_rd_wr");
      compare(mem_rd_addr, rec.rd_addr, "mem_rd_addr");
      if (!haz && is_br) begin
        compare(bj_taken, calc_taken(rec.branch_op, v1, v2), "bj_taken");
        compare(bj_target, calc_target(rec.branch_op, rec.pc, rec.imm, v1), "bj_target");
      end
      if (!haz) begin
        op1 = rec.use_rs1 ? v1 : rec.op1;
        op2 = rec.use_rs2 ? v2 : rec.op2;
        compare(mem_result, calc_alu(op1, op2, rec.alu_op, rec.word), "mem_result");
        compare(mem_store_data, v2, "mem_store_data");
      end
      if (exp_allowin) begin
        void'(pending.pop_front());
        retired_count++;
      end
    end
    if (id_valid && exp_allowin) begin
      incoming.pc = id_pc;
      incoming.alu_op = id_alu_op;
      incoming.branch_op = id_branch_op;
      incoming.word = id_word;
      incoming.use_rs1 = id_use_rs1;
      incoming.use_rs2 = id_use_rs2;
      incoming.rs1_addr = id_rs1_addr;
      incoming.rs2_addr = id_rs2_addr;
      incoming.op1 = id_op1;
      incoming.op2 = id_op2;
      incoming.imm = id_imm;
      incoming.rd_wr = id_rd_wr;
      incoming.rd_addr = id_rd_addr;
      pending.push_back(incoming);
      accepted_count++;
    end
  endtask

  // inputs change at the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst !== 1'b0) begin
      mirror_update(1'b1);
    end else begin
      allowin_seen = ex_allowin;
      check_cycle();
      mirror_update(1'b0);
    end
  end

  initial begin
    void'($urandom(32'h21ef_6cc3));
    error_count = 0;
    accepted_count = 0;
    retired_count = 0;
    rst = 1'b1;
    id_valid = 1'b0;
    id_pc = '0;
    id_alu_op = ex_pkg::alu_add;
    id_branch_op = ex_pkg::br_none;
    id_word = 1'b0;
    id_use_rs1 = 1'b0;
    id_use_rs2 = 1'b0;
    id_rs1_addr = '0;
    id_rs2_addr = '0;
    id_op1 = '0;
    id_op2 = '0;
    id_imm = '0;
    id_rd_wr = 1'b0;
    id_rd_addr = '0;
    mem_allowin = 1'b0;
    mem_fwd_wr = 1'b0;
    mem_fwd_load = 1'b0;
    mem_fwd_addr = '0;
    mem_fwd_data = '0;
    wb_wr = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    bj_ready = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    while (accepted_count < NUM_INSTR) begin
      drive_cycle();
      @(posedge clk);
    end
    // drain the last instruction with no stalls
    id_valid <= 1'b0;
    mem_allowin <= 1'b1;
    bj_ready <= 1'b1;
    mem_fwd_load <= 1'b0;
    while (pending.size() != 0) begin
      @(posedge clk);
    end
    $display("errors: %0d, accepted: %0d, retired: %0d", error_count, accepted_count,
             retired_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #((TIMEOUT_CYCLES + 10) * CLK_PERIOD);
    $display("timeout: only %0d of %0d instructions retired", retired_count, NUM_INSTR);
    $display("tests failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+source
+incdir+tests
source/ex_pkg.sv
source/gpr_file.sv
source/ex_forward.sv
source/ex_alu.sv
source/ex_branch.sv
source/ex_stage.sv
source/ex_top.sv
tests/tb_ex_top.sv

// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		-f project.f --top-module tb_ex_top -Mdir obj_dir
	./obj_dir/Vtb_ex_top > sim.log 2>&1; cat sim.log
	@if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
